// File: common/bus_pkg.sv
package bus_pkg;

	// Wishbone and peripheral bus widths
	localparam int BUS_ADDR_W = 24;
	localparam int BUS_DATA_W = 32;
	localparam int BUS_SEL_W  = 4;

	// Frame buffer window, 64 words of 32 bits
	localparam logic [BUS_ADDR_W-1:0] MEM_BASE = 24'h000000;
	localparam int MEM_SPAN_BYTES = 256;

	// VGA register block
	localparam logic [BUS_ADDR_W-1:0] VGA_BASE = 24'h100000;
	localparam logic [BUS_ADDR_W-1:0] REG_CONTROL_OFFSET = 24'h000000;	// Bit 0 enables display
	localparam logic [BUS_ADDR_W-1:0] REG_STATUS_OFFSET  = 24'h000004;	// Read only

	// Returned when no peripheral claims the address
	localparam logic [BUS_DATA_W-1:0] UNMAPPED_DATA = '1;

	typedef enum logic [1:0] {
		WB_IDLE,	// Ready for a new request
		WB_ISSUE,	// Strobe out on the peripheral bus
		WB_WAIT	// Peripheral still busy
	} wb_state_e;

endpackage

// File: common/video_pkg.sv
package video_pkg;

	// Reduced display mode, one clock per pixel
	localparam int H_VISIBLE = 32;
	localparam int H_FRONT   = 4;
	localparam int H_SYNC    = 4;
	localparam int H_BACK    = 4;
	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_VISIBLE = 8;
	localparam int V_FRONT   = 1;
	localparam int V_SYNC    = 2;
	localparam int V_BACK    = 1;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_CNT_W   = $clog2(H_TOTAL);
	localparam int V_CNT_W   = $clog2(V_TOTAL);

	// Frame buffer geometry
	localparam int PIXELS_PER_WORD = 4;
	localparam int PIXEL_SEL_W     = $clog2(PIXELS_PER_WORD);
	localparam int WORDS_PER_LINE  = H_VISIBLE / PIXELS_PER_WORD;
	localparam int FB_ADDR_W       = 6;
	localparam int FETCH_LATENCY   = 2;	// Pixel counter to pins

	// Pixel byte is 2:2:2 RGB, top two bits unused
	localparam int COLOUR_W  = 2;
	localparam int PIXEL_W   = 8;
	localparam int RED_LSB   = 4;
	localparam int GREEN_LSB = 2;
	localparam int BLUE_LSB  = 0;

	// Register bits
	localparam int CTRL_ENABLE_BIT   = 0;
	localparam int STATUS_VBLANK_BIT = 16;

	typedef enum logic [1:0] {REGION_VISIBLE, REGION_FRONT, REGION_SYNC, REGION_BACK} fetch_state_e;

endpackage

// File: hdl/wb_peripheral_bus_interface.sv
`timescale 1ns/1ps

module wb_peripheral_bus_interface (
	input  logic                             wb_clk_i,
	input  logic                             reset_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_cyc_i,
	input  logic                             wb_we_i,
	input  logic [bus_pkg::BUS_SEL_W-1:0]    wb_sel_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]   wb_data_i,
	input  logic [bus_pkg::BUS_ADDR_W-1:0]   wb_adr_i,
	output logic                             wb_ack_o,
	output logic                             wb_stall_o,
	output logic                             wb_error_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]   wb_data_o,
	input  logic                             pbus_busy_i,
	input  logic                             pbus_hit_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]   pbus_data_read_i,
	output logic                             pbus_we_o,
	output logic                             pbus_oe_o,
	output logic [bus_pkg::BUS_ADDR_W-1:0]   pbus_address_o,
	output logic [bus_pkg::BUS_SEL_W-1:0]    pbus_byte_select_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]   pbus_data_write_o
);

	import bus_pkg::*;

	wb_state_e state;
	logic accept;
	logic done;
	logic we_q;

	assign accept = wb_stb_i && wb_cyc_i && !wb_stall_o;
	assign done = (state != WB_IDLE) && !pbus_busy_i;	// Peripheral has finished

	assign wb_stall_o = (state != WB_IDLE);
	assign pbus_we_o = (state == WB_ISSUE) && we_q;	// Single cycle strobes
	assign pbus_oe_o = (state == WB_ISSUE) && !we_q;

	// Request is held on the bus until the transfer completes
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			we_q <= wb_we_i;
			pbus_address_o <= wb_adr_i;
			pbus_byte_select_o <= wb_sel_i;
			pbus_data_write_o <= wb_data_i;
		end
		if (done)
			wb_data_o <= pbus_data_read_i;
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state <= WB_IDLE;
			wb_ack_o <= 1'b0;
			wb_error_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			wb_error_o <= 1'b0;
			case (state)
				WB_IDLE: if (accept) state <= WB_ISSUE;
				WB_ISSUE, WB_WAIT: begin
					if (done) begin
						wb_ack_o <= pbus_hit_i;
						wb_error_o <= !pbus_hit_i;	// Nobody claimed the address
						state <= WB_IDLE;
					end else begin
						state <= WB_WAIT;
					end
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

endmodule

// File: video_memory/frame_buffer_sram.sv
`timescale 1ns/1ps

module frame_buffer_sram (
	input  logic                              wb_clk_i,
	input  logic                              rw_enable_i,
	input  logic                              rw_write_i,
	input  logic [bus_pkg::BUS_SEL_W-1:0]     rw_mask_i,
	input  logic [video_pkg::FB_ADDR_W-1:0]   rw_addr_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    rw_data_i,
	output logic [bus_pkg::BUS_DATA_W-1:0]    rw_data_o,
	input  logic                              r_enable_i,
	input  logic [video_pkg::FB_ADDR_W-1:0]   r_addr_i,
	output logic [bus_pkg::BUS_DATA_W-1:0]    r_data_o
);

	import bus_pkg::*;
	import video_pkg::*;

	localparam int BYTE_W = BUS_DATA_W / BUS_SEL_W;

	logic [BUS_DATA_W-1:0] mem [2**FB_ADDR_W];

	always_ff @(posedge wb_clk_i) begin
		if (rw_enable_i) begin
			if (rw_write_i) begin
				for (int i = 0; i < BUS_SEL_W; i++) begin
					if (rw_mask_i[i])
						mem[rw_addr_i][i*BYTE_W +: BYTE_W] <= rw_data_i[i*BYTE_W +: BYTE_W];
				end
			end else begin
				rw_data_o <= mem[rw_addr_i];	// Output holds until next read
			end
		end
		if (r_enable_i)
			r_data_o <= mem[r_addr_i];
	end

endmodule

// File: video_memory/video_memory.sv
`timescale 1ns/1ps

module video_memory (
	input  logic                              wb_clk_i,
	input  logic                              reset_i,
	input  logic                              pbus_we_i,
	input  logic                              pbus_oe_i,
	input  logic [bus_pkg::BUS_ADDR_W-1:0]    pbus_address_i,
	input  logic [bus_pkg::BUS_SEL_W-1:0]     pbus_byte_select_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    pbus_data_write_i,
	output logic                              busy_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]    data_read_o,
	output logic                              request_output_o,
	input  logic [video_pkg::FB_ADDR_W-1:0]   video_address_i,
	output logic [bus_pkg::BUS_DATA_W-1:0]    video_data_o
);

	import bus_pkg::*;
	import video_pkg::*;

	logic [BUS_ADDR_W-1:0] offset;
	logic [FB_ADDR_W-1:0] word_address;
	logic access;

	// Window decode, byte offset into the frame buffer
	assign offset = pbus_address_i - MEM_BASE;
	assign request_output_o = (offset < MEM_SPAN_BYTES);
	assign word_address = offset[$clog2(BUS_SEL_W) +: FB_ADDR_W];

	// No array access while in reset
	assign access = (pbus_we_i || pbus_oe_i) && request_output_o && !reset_i;

	// Read data arrives the cycle after the strobe
	assign busy_o = pbus_oe_i && request_output_o;

	frame_buffer_sram frame_buffer_sram_inst (
		.wb_clk_i   (wb_clk_i),
		.rw_enable_i(access),
		.rw_write_i (pbus_we_i),
		.rw_mask_i  (pbus_byte_select_i),
		.rw_addr_i  (word_address),
		.rw_data_i  (pbus_data_write_i),
		.rw_data_o  (data_read_o),
		.r_enable_i (1'b1),	// Display reads every cycle
		.r_addr_i   (video_address_i),
		.r_data_o   (video_data_o)
	);

endmodule

// File: vga/vga_controller.sv
`timescale 1ns/1ps

module vga_controller (
	input  logic                              wb_clk_i,
	input  logic                              reset_i,
	input  logic                              pbus_we_i,
	input  logic                              pbus_oe_i,
	input  logic [bus_pkg::BUS_ADDR_W-1:0]    pbus_address_i,
	input  logic [bus_pkg::BUS_SEL_W-1:0]     pbus_byte_select_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    pbus_data_write_i,
	output logic                              busy_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]    data_read_o,
	output logic                              request_output_o,
	output logic [video_pkg::FB_ADDR_W-1:0]   video_address_o,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    video_data_i,
	output logic [video_pkg::COLOUR_W-1:0]    vga_r_o,
	output logic [video_pkg::COLOUR_W-1:0]    vga_g_o,
	output logic [video_pkg::COLOUR_W-1:0]    vga_b_o,
	output logic                              vga_hsync_o,
	output logic                              vga_vsync_o
);

	import bus_pkg::*;
	import video_pkg::*;

	function automatic fetch_state_e region_of(input int count, input int visible,
			input int front, input int sync);
		fetch_state_e region;
		if (count < visible)
			region = REGION_VISIBLE;
		else if (count < visible + front)
			region = REGION_FRONT;
		else if (count < visible + front + sync)
			region = REGION_SYNC;
		else
			region = REGION_BACK;
		return region;
	endfunction

	logic [H_CNT_W-1:0] h_count;
	logic [V_CNT_W-1:0] v_count;
	fetch_state_e h_region;
	fetch_state_e v_region;
	logic ctrl_enable;
	logic control_sel;
	logic status_sel;
	logic [BUS_DATA_W-1:0] reg_data;
	logic [PIXEL_SEL_W-1:0] byte_sel_q;
	logic visible_q;
	logic [PIXEL_W-1:0] pixel;
	logic [FETCH_LATENCY-1:0] hsync_pipe;
	logic [FETCH_LATENCY-1:0] vsync_pipe;

	// Register block
	assign control_sel = (pbus_address_i == VGA_BASE + REG_CONTROL_OFFSET);
	assign status_sel = (pbus_address_i == VGA_BASE + REG_STATUS_OFFSET);
	assign request_output_o = control_sel || status_sel;
	assign busy_o = 1'b0;	// Registers answer in the strobe cycle

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			ctrl_enable <= 1'b0;
		else if (pbus_we_i && control_sel && pbus_byte_select_i[CTRL_ENABLE_BIT / 8])
			ctrl_enable <= pbus_data_write_i[CTRL_ENABLE_BIT];
	end

	always_comb begin
		reg_data = '0;
		if (control_sel) begin
			reg_data[CTRL_ENABLE_BIT] = ctrl_enable;
		end else if (status_sel) begin
			reg_data[V_CNT_W-1:0] = v_count;	// Current line
			reg_data[STATUS_VBLANK_BIT] = (v_region != REGION_VISIBLE);
		end
	end

	assign data_read_o = pbus_oe_i ? reg_data : '0;

	// Counters free run and enable only blanks the colours
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == H_CNT_W'(H_TOTAL - 1)) begin
			h_count <= '0;
			if (v_count == V_CNT_W'(V_TOTAL - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign h_region = region_of(int'(h_count), H_VISIBLE, H_FRONT, H_SYNC);
	assign v_region = region_of(int'(v_count), V_VISIBLE, V_FRONT, V_SYNC);

	// Data for this pixel group's word comes back next cycle
	assign video_address_o = FB_ADDR_W'(v_count * WORDS_PER_LINE + (h_count >> PIXEL_SEL_W));

	always_ff @(posedge wb_clk_i) begin
		byte_sel_q <= h_count[PIXEL_SEL_W-1:0];
		if (reset_i)
			visible_q <= 1'b0;
		else
			visible_q <= ctrl_enable && (h_region == REGION_VISIBLE)
				&& (v_region == REGION_VISIBLE);
	end

	assign pixel = video_data_i[byte_sel_q*PIXEL_W +: PIXEL_W];

	always_ff @(posedge wb_clk_i) begin
		if (reset_i || !visible_q) begin
			vga_r_o <= '0;
			vga_g_o <= '0;
			vga_b_o <= '0;
		end else begin
			vga_r_o <= pixel[RED_LSB +: COLOUR_W];
			vga_g_o <= pixel[GREEN_LSB +: COLOUR_W];
			vga_b_o <= pixel[BLUE_LSB +: COLOUR_W];
		end
	end

	// Syncs delayed to line up with the colour pipeline
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			hsync_pipe <= '1;
			vsync_pipe <= '1;
		end else begin
			hsync_pipe <= {hsync_pipe[FETCH_LATENCY-2:0], h_region != REGION_SYNC};
			vsync_pipe <= {vsync_pipe[FETCH_LATENCY-2:0], v_region != REGION_SYNC};
		end
	end

	assign vga_hsync_o = hsync_pipe[FETCH_LATENCY-1];	// Active low
	assign vga_vsync_o = vsync_pipe[FETCH_LATENCY-1];

endmodule

// File: hdl/video.sv
`timescale 1ns/1ps

module video (
	input  logic                              wb_clk_i,
	input  logic                              reset_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_we_i,
	input  logic [bus_pkg::BUS_SEL_W-1:0]     wb_sel_i,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    wb_data_i,
	input  logic [bus_pkg::BUS_ADDR_W-1:0]    wb_adr_i,
	output logic                              wb_ack_o,
	output logic                              wb_stall_o,
	output logic                              wb_error_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]    wb_data_o,
	output logic [video_pkg::COLOUR_W-1:0]    vga_r_o,
	output logic [video_pkg::COLOUR_W-1:0]    vga_g_o,
	output logic [video_pkg::COLOUR_W-1:0]    vga_b_o,
	output logic                              vga_hsync_o,
	output logic                              vga_vsync_o
);

	import bus_pkg::*;
	import video_pkg::*;

	logic pbus_we;
	logic pbus_oe;
	logic pbus_busy;
	logic pbus_hit;
	logic [BUS_ADDR_W-1:0] pbus_address;
	logic [BUS_SEL_W-1:0] pbus_byte_select;
	logic [BUS_DATA_W-1:0] pbus_data_write;
	logic [BUS_DATA_W-1:0] pbus_data_read;
	logic mem_busy;
	logic mem_request_output;
	logic [BUS_DATA_W-1:0] mem_data_read;
	logic vga_busy;
	logic vga_request_output;
	logic [BUS_DATA_W-1:0] vga_data_read;
	logic [FB_ADDR_W-1:0] video_address;
	logic [BUS_DATA_W-1:0] video_data;

	wb_peripheral_bus_interface wb_peripheral_bus_interface_inst (
		.wb_clk_i, .reset_i, .wb_stb_i, .wb_cyc_i, .wb_we_i, .wb_sel_i, .wb_data_i, .wb_adr_i,
		.wb_ack_o, .wb_stall_o, .wb_error_o, .wb_data_o,
		.pbus_busy_i       (pbus_busy),
		.pbus_hit_i        (pbus_hit),
		.pbus_data_read_i  (pbus_data_read),
		.pbus_we_o         (pbus_we),
		.pbus_oe_o         (pbus_oe),
		.pbus_address_o    (pbus_address),
		.pbus_byte_select_o(pbus_byte_select),
		.pbus_data_write_o (pbus_data_write)
	);

	video_memory video_memory_inst (
		.wb_clk_i, .reset_i,
		.pbus_we_i         (pbus_we),
		.pbus_oe_i         (pbus_oe),
		.pbus_address_i    (pbus_address),
		.pbus_byte_select_i(pbus_byte_select),
		.pbus_data_write_i (pbus_data_write),
		.busy_o            (mem_busy),
		.data_read_o       (mem_data_read),
		.request_output_o  (mem_request_output),
		.video_address_i   (video_address),
		.video_data_o      (video_data)
	);

	vga_controller vga_controller_inst (
		.wb_clk_i, .reset_i,
		.pbus_we_i         (pbus_we),
		.pbus_oe_i         (pbus_oe),
		.pbus_address_i    (pbus_address),
		.pbus_byte_select_i(pbus_byte_select),
		.pbus_data_write_i (pbus_data_write),
		.busy_o            (vga_busy),
		.data_read_o       (vga_data_read),
		.request_output_o  (vga_request_output),
		.video_address_o   (video_address),
		.video_data_i      (video_data),
		.vga_r_o, .vga_g_o, .vga_b_o, .vga_hsync_o, .vga_vsync_o
	);

	assign pbus_busy = mem_busy || vga_busy;
	assign pbus_hit = mem_request_output || vga_request_output;

	// Claiming peripheral drives read data
	assign pbus_data_read = mem_request_output ? mem_data_read :
		vga_request_output ? vga_data_read : UNMAPPED_DATA;

endmodule

// File: verif/video_tb_tasks.svh
`ifndef VIDEO_TB_TASKS_SVH
`define VIDEO_TB_TASKS_SVH

task automatic compare_word(input string name, input logic [BUS_DATA_W-1:0] actual,
		input logic [BUS_DATA_W-1:0] expected);
	if (actual !== expected) begin
		$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		test_errors++;
	end
endtask

task automatic compare_colour(input string name, input logic [COLOUR_W-1:0] actual,
		input logic [COLOUR_W-1:0] expected);
	if (actual !== expected) begin
		$display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
		test_errors++;
	end
endtask

task automatic compare_flag(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		$display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
		test_errors++;
	end
endtask

// Entered and left 2 ns after a rising edge
task automatic wb_transfer(input logic we, input logic [BUS_ADDR_W-1:0] addr,
		input logic [BUS_DATA_W-1:0] data, input logic [BUS_SEL_W-1:0] sel,
		output logic [BUS_DATA_W-1:0] rdata, output logic acked, output logic errored);
	int cycles;
	wb_stb = 1'b1;
	wb_cyc = 1'b1;
	wb_we = we;
	wb_adr = addr;
	wb_sel = sel;
	wb_wdata = data;
	cycles = 0;
	while (wb_stall && cycles < WAIT_LIMIT) begin
		@(posedge clk);
		#2;
		cycles++;
	end
	if (wb_stall) begin
		timeout_abort("wb_stall_o to drop");
	end else begin
		@(posedge clk);	// Request taken on this edge
		#2;
		wb_stb = 1'b0;
		compare_flag("wb_stall_o after acceptance", wb_stall, 1'b1);
		cycles = 0;
		while (!wb_ack && !wb_error && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!wb_ack && !wb_error) begin
			timeout_abort("wb_ack_o or wb_error_o");
		end else begin
			compare_flag("wb_stall_o at completion", wb_stall, 1'b0);
			rdata = wb_rdata;
			acked = wb_ack;
			errored = wb_error;
			wb_cyc = 1'b0;
			wb_we = 1'b0;
		end
	end
endtask

task automatic wb_write(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data,
		input logic [BUS_SEL_W-1:0] sel, output logic acked, output logic errored);
	logic [BUS_DATA_W-1:0] unused;
	wb_transfer(1'b1, addr, data, sel, unused, acked, errored);
endtask

task automatic wb_read(input logic [BUS_ADDR_W-1:0] addr, output logic [BUS_DATA_W-1:0] rdata,
		output logic acked, output logic errored);
	wb_transfer(1'b0, addr, '0, '1, rdata, acked, errored);
endtask

task automatic wait_sync_rise(input logic vertical);
	logic prev;
	logic cur;
	int cycles;
	prev = vertical ? vsync : hsync;
	cur = prev;
	cycles = 0;
	while (!(cur && !prev) && cycles < FRAME_LIMIT) begin
		@(posedge clk);
		#2;
		prev = cur;
		cur = vertical ? vsync : hsync;
		cycles++;
	end
	if (!(cur && !prev))
		timeout_abort(vertical ? "vsync rising edge" : "hsync rising edge");
endtask

// Row 0 starts with the back porch of the first visible line
task automatic capture_frame();
	logic prev_hsync;
	logic prev_vsync;
	wait_sync_rise(1'b1);
	for (int i = 0; i < V_BACK; i++)
		wait_sync_rise(1'b0);
	hsync_pulses = 0;
	vsync_pulses = 0;
	prev_hsync = hsync;
	prev_vsync = vsync;
	for (int row = 0; row < V_TOTAL; row++) begin
		for (int col = 0; col < H_TOTAL; col++) begin
			if (row != 0 || col != 0) begin
				@(posedge clk);
				#2;
			end
			cap_r[row][col] = vga_r;
			cap_g[row][col] = vga_g;
			cap_b[row][col] = vga_b;
			if (prev_hsync && !hsync)
				hsync_pulses++;
			if (prev_vsync && !vsync)
				vsync_pulses++;
			prev_hsync = hsync;
			prev_vsync = vsync;
		end
	end
endtask

`endif

// File: verif/video_tb.sv
`timescale 1ns/1ps

module video_tb;

	import bus_pkg::*;
	import video_pkg::*;

	localparam int WAIT_LIMIT = 64;
	localparam int POLL_LIMIT = 1000;
	localparam int FRAME_LIMIT = 2 * H_TOTAL * V_TOTAL;
	localparam int FB_WORDS = 2 ** FB_ADDR_W;
	localparam logic [BUS_ADDR_W-1:0] CONTROL_ADDR = VGA_BASE + REG_CONTROL_OFFSET;
	localparam logic [BUS_ADDR_W-1:0] STATUS_ADDR = VGA_BASE + REG_STATUS_OFFSET;

	logic clk;
	logic reset;
	logic wb_stb;
	logic wb_cyc;
	logic wb_we;
	logic [BUS_SEL_W-1:0] wb_sel;
	logic [BUS_DATA_W-1:0] wb_wdata;
	logic [BUS_ADDR_W-1:0] wb_adr;
	logic wb_ack;
	logic wb_stall;
	logic wb_error;
	logic [BUS_DATA_W-1:0] wb_rdata;
	logic [COLOUR_W-1:0] vga_r;
	logic [COLOUR_W-1:0] vga_g;
	logic [COLOUR_W-1:0] vga_b;
	logic hsync;
	logic vsync;

	logic [BUS_DATA_W-1:0] shadow [FB_WORDS];
	logic [COLOUR_W-1:0] cap_r [V_TOTAL][H_TOTAL];
	logic [COLOUR_W-1:0] cap_g [V_TOTAL][H_TOTAL];
	logic [COLOUR_W-1:0] cap_b [V_TOTAL][H_TOTAL];
	int hsync_pulses;
	int vsync_pulses;
	int test_errors;
	int test_count;
	int tests_passed;
	int tests_failed;
	int unsigned seed;

	video video_inst (
		.wb_clk_i(clk), .reset_i(reset),
		.wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
		.wb_data_i(wb_wdata), .wb_adr_i(wb_adr),
		.wb_ack_o(wb_ack), .wb_stall_o(wb_stall), .wb_error_o(wb_error), .wb_data_o(wb_rdata),
		.vga_r_o(vga_r), .vga_g_o(vga_g), .vga_b_o(vga_b),
		.vga_hsync_o(hsync), .vga_vsync_o(vsync)
	);

	always #10 clk = ~clk;

	`include "video_tb_tasks.svh"

	task automatic finish_run();
		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		$display("Error at %0t: timed out waiting for %s", $time, what);
		tests_failed++;
		finish_run();
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (test_errors == 0) begin
			$display("Test %0d %s: ok", test_count, name);
			tests_passed++;
		end else begin
			$display("Test %0d %s: %0d errors", test_count, name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	function automatic logic [BUS_DATA_W-1:0] merge_bytes(input logic [BUS_DATA_W-1:0] old_word,
			input logic [BUS_DATA_W-1:0] new_word, input logic [BUS_SEL_W-1:0] sel);
		logic [BUS_DATA_W-1:0] merged;
		merged = old_word;
		for (int i = 0; i < BUS_SEL_W; i++)
			if (sel[i])
				merged[i*8 +: 8] = new_word[i*8 +: 8];
		return merged;
	endfunction

	task automatic fill_frame_buffer();
		logic acked;
		logic errored;
		for (int i = 0; i < FB_WORDS; i++) begin
			shadow[i] = $urandom();
			wb_write(MEM_BASE + BUS_ADDR_W'(i * 4), shadow[i], '1, acked, errored);
			compare_flag("wb_ack_o on fill", acked, 1'b1);
		end
	endtask

	// Pixel byte holds red in 5:4, green in 3:2 and blue in 1:0
	task automatic check_frame(input logic enabled);
		logic [PIXEL_W-1:0] pixel;
		int x;
		int word;
		for (int row = 0; row < V_TOTAL; row++) begin
			for (int col = 0; col < H_TOTAL; col++) begin
				x = col - H_BACK;
				pixel = '0;
				if (enabled && row < V_VISIBLE && x >= 0 && x < H_VISIBLE) begin
					word = row * (H_VISIBLE / PIXELS_PER_WORD) + x / PIXELS_PER_WORD;
					pixel = shadow[word][(x % PIXELS_PER_WORD) * 8 +: 8];
				end
				compare_colour($sformatf("vga_r_o row %0d col %0d", row, col),
					cap_r[row][col], pixel[5:4]);
				compare_colour($sformatf("vga_g_o row %0d col %0d", row, col),
					cap_g[row][col], pixel[3:2]);
				compare_colour($sformatf("vga_b_o row %0d col %0d", row, col),
					cap_b[row][col], pixel[1:0]);
			end
		end
		compare_word("hsync pulses per frame", hsync_pulses, V_TOTAL);
		compare_word("vsync pulses per frame", vsync_pulses, 1);
	endtask

	task automatic test_reset_state();
		logic [BUS_DATA_W-1:0] rdata;
		logic acked;
		logic errored;
		compare_flag("wb_ack_o", wb_ack, 1'b0);
		compare_flag("wb_error_o", wb_error, 1'b0);
		compare_flag("wb_stall_o", wb_stall, 1'b0);
		compare_flag("vga_hsync_o", hsync, 1'b1);
		compare_flag("vga_vsync_o", vsync, 1'b1);
		wb_read(CONTROL_ADDR, rdata, acked, errored);
		compare_flag("wb_ack_o", acked, 1'b1);
		compare_word("control register", rdata, '0);
		capture_frame();
		check_frame(1'b0);
	endtask

	task automatic test_memory();
		logic [BUS_DATA_W-1:0] rdata;
		logic [BUS_DATA_W-1:0] data;
		logic [BUS_SEL_W-1:0] sel;
		logic acked;
		logic errored;
		int word;
		fill_frame_buffer();
		for (int i = 0; i < FB_WORDS; i += 4) begin
			sel = BUS_SEL_W'(i / 4);	// Every mask pattern once
			word = i + (i / 4) % 4;
			data = $urandom();
			wb_write(MEM_BASE + BUS_ADDR_W'(word * 4), data, sel, acked, errored);
			compare_flag("wb_ack_o on masked write", acked, 1'b1);
			shadow[word] = merge_bytes(shadow[word], data, sel);
		end
		for (int i = 0; i < FB_WORDS; i++) begin
			wb_read(MEM_BASE + BUS_ADDR_W'(i * 4), rdata, acked, errored);
			compare_flag("wb_ack_o on read", acked, 1'b1);
			compare_word($sformatf("frame buffer word %0d", i), rdata, shadow[i]);
		end
	endtask

	task automatic test_registers();
		logic [BUS_DATA_W-1:0] rdata;
		logic acked;
		logic errored;
		int polls;
		wb_write(CONTROL_ADDR, 32'h1, '1, acked, errored);
		compare_flag("wb_ack_o on control write", acked, 1'b1);
		wb_read(CONTROL_ADDR, rdata, acked, errored);
		compare_word("control register", rdata, 32'h1);
		polls = 0;
		wb_read(STATUS_ADDR, rdata, acked, errored);
		while (!rdata[STATUS_VBLANK_BIT] && polls < POLL_LIMIT) begin
			wb_read(STATUS_ADDR, rdata, acked, errored);
			polls++;
		end
		if (!rdata[STATUS_VBLANK_BIT])
			timeout_abort("vertical blank flag in status");
		else
			compare_flag($sformatf("status line %0d in blanking", rdata[15:0]),
				rdata[15:0] >= V_VISIBLE && rdata[15:0] < V_TOTAL, 1'b1);
	endtask

	task automatic test_unmapped();
		logic [BUS_DATA_W-1:0] rdata;
		logic acked;
		logic errored;
		wb_read(24'h200000, rdata, acked, errored);
		compare_flag("wb_error_o", errored, 1'b1);
		compare_flag("wb_ack_o", acked, 1'b0);
		compare_word("wb_data_o", rdata, '1);
		wb_read(24'h000100, rdata, acked, errored);	// Just past the frame buffer
		compare_flag("wb_error_o", errored, 1'b1);
		compare_flag("wb_ack_o", acked, 1'b0);
		compare_word("wb_data_o", rdata, '1);
		wb_write(24'h100008, 32'h1, '1, acked, errored);
		compare_flag("wb_error_o on write", errored, 1'b1);
		compare_flag("wb_ack_o on write", acked, 1'b0);
	endtask

	task automatic test_display();
		logic acked;
		logic errored;
		fill_frame_buffer();
		wb_write(CONTROL_ADDR, 32'h1, '1, acked, errored);
		compare_flag("wb_ack_o on enable", acked, 1'b1);
		capture_frame();
		check_frame(1'b1);
	endtask

	task automatic test_disable();
		logic acked;
		logic errored;
		wb_write(CONTROL_ADDR, 32'h0, '1, acked, errored);
		compare_flag("wb_ack_o on disable", acked, 1'b1);
		capture_frame();
		check_frame(1'b0);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		wb_we = 1'b0;
		wb_sel = '0;
		wb_wdata = '0;
		wb_adr = '0;
		test_errors = 0;
		test_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		seed = 32'h238b;
		void'($urandom(seed));
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset_state();
		end_test("reset state");
		test_memory();
		end_test("memory byte masks");
		test_registers();
		end_test("registers");
		test_unmapped();
		end_test("unmapped access");
		test_display();
		end_test("displayed frame");
		test_disable();
		end_test("display disable");
		finish_run();
	end

endmodule

// File: compile.f
+incdir+verif
common/bus_pkg.sv
common/video_pkg.sv
hdl/wb_peripheral_bus_interface.sv
video_memory/frame_buffer_sram.sv
video_memory/video_memory.sv
vga/vga_controller.sv
hdl/video.sv
verif/video_tb.sv
